//--- rv_mem.f
hdl/rv_mem_pkg.sv
hdl/dbus_if.sv
hdl/lsu.sv
hdl/data_ram.sv
hdl/mem_stage.sv
hdl/rv_mem_top.sv
test/rv_mem_tb.sv

//--- run.sh
#!/bin/sh
# Compile and run the memory stage testbench with Verilator
# Exit status is nonzero when the build or the simulation fails
set -e

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/100ps \
    --top-module rv_mem_tb \
    -f rv_mem.f \
    -Mdir obj_dir

./obj_dir/Vrv_mem_tb

//--- test/rv_mem_input.txt
# st fl v rw rd mr mw op alu_out writedata chk  exp: v rw rd lm sm writedata  (all hex)
# op: 0 LB 1 LH 2 LW 3 SW 4 LBU 5 LHU 6 SB 7 SH; chk: 0 none 1 control 2 control and data
0 0 0 0 00 0 0 0 00000000 00000000 1 0 0 00 0 0 00000000
0 0 0 0 00 0 0 0 00000000 00000000 1 0 0 00 0 0 00000000
0 0 1 0 00 0 1 3 00000100 11223344 1 0 0 00 0 0 00000000
0 0 1 0 00 0 1 7 00000106 1234f00d 1 0 0 00 0 0 00000000
0 0 1 0 00 0 1 6 00000105 00000080 2 1 0 00 0 0 00000100
0 0 1 0 00 0 1 6 00000101 ffffff9a 2 1 0 00 0 0 00000106
0 0 1 0 00 0 1 3 00000408 cafe0123 2 1 0 00 0 0 00000105
0 0 1 1 05 1 0 2 00000100 00000000 2 1 0 00 0 0 00000101
0 0 1 1 06 1 0 1 00000106 00000000 2 1 0 00 0 0 00000408
0 0 1 1 07 1 0 5 00000106 00000000 2 1 1 05 0 0 11229a44
0 0 1 1 08 1 0 0 00000105 00000000 2 1 1 06 0 0 fffff00d
0 0 1 1 09 1 0 4 00000101 00000000 2 1 1 07 0 0 0000f00d
0 0 1 1 0a 1 0 2 00000008 00000000 2 1 1 08 0 0 ffffff80
0 0 1 1 0b 1 0 1 00000102 00000000 2 1 1 09 0 0 0000009a
0 0 1 1 01 0 0 0 00000011 00000000 2 1 1 0a 0 0 cafe0123
0 0 1 1 02 0 0 0 a5a5a5a5 00000000 2 1 1 0b 0 0 00001122
0 0 1 1 03 0 0 0 ffffffff 00000000 2 1 1 01 0 0 00000011
0 0 1 0 00 0 0 0 12345678 00000000 2 1 1 02 0 0 a5a5a5a5
0 0 1 1 0c 1 0 1 00000103 00000000 2 1 1 03 0 0 ffffffff
0 0 1 0 00 0 1 3 00000102 0badf00d 2 1 0 00 0 0 12345678
0 0 1 1 0d 1 0 2 00000100 00000000 2 1 1 0c 1 0 00000103
0 0 1 1 10 0 0 0 00002222 00000000 2 1 0 00 0 1 00000102
0 0 1 1 0e 1 0 2 00000104 00000000 2 1 1 0d 0 0 11229a44
1 0 1 1 0f 0 0 0 00000777 00000000 2 1 1 10 0 0 00002222
1 0 1 1 0f 0 0 0 00000777 00000000 2 1 1 10 0 0 00002222
1 0 1 1 0f 0 0 0 00000777 00000000 2 1 1 10 0 0 00002222
0 0 1 1 0f 0 0 0 00000777 00000000 2 1 1 10 0 0 00002222
0 0 0 0 00 0 0 0 00000000 00000000 2 1 1 0e 0 0 f00d8000
0 0 1 0 00 0 1 3 0000010c 5eed5eed 2 1 1 0f 0 0 00000777
0 1 1 1 11 0 0 0 00003333 00000000 1 0 0 00 0 0 00000000
0 0 1 1 12 1 0 2 0000010c 00000000 1 0 0 00 0 0 00000000
0 0 0 0 00 0 0 0 00000000 00000000 2 1 1 11 0 0 00003333
0 0 0 0 00 0 0 0 00000000 00000000 2 1 1 12 0 0 5eed5eed
0 0 0 0 00 0 0 0 00000000 00000000 1 0 0 00 0 0 00000000

//--- test/rv_mem_tb.sv
// ----------------------------------------------------------------------
// Testbench for the memory stage subsystem
// Replays test/rv_mem_input.txt one line per clock cycle and checks
// the write-back record and data against the expected columns
// ----------------------------------------------------------------------

`timescale 1ns/100ps

module rv_mem_tb;

    localparam int CLK_HALF     = 50;
    localparam int DRIVE_DELAY  = 10;
    localparam int SAMPLE_DELAY = 80;
    localparam int RESET_CYCLES = 5;
    localparam int MAX_CYCLES   = 200;
    localparam int MIN_LINES    = 34;
    localparam int FIELDS       = 17;

    // ------------------------------------------------------------------
    // DUT signals
    // ------------------------------------------------------------------

    logic                               clk;
    logic                               rst;
    logic                               stall;
    logic                               flush;
    logic                               ex_valid;
    logic                               ex_reg_write;
    logic [rv_mem_pkg::REG_ADDR_W-1:0]  ex_rd;
    logic                               ex_mem_read;
    logic                               ex_mem_write;
    rv_mem_pkg::mem_op_e                ex_mem_opcode;
    logic [rv_mem_pkg::DATA_W-1:0]      ex_alu_out;
    logic [rv_mem_pkg::DATA_W-1:0]      ex_writedata;
    logic                               wb_valid;
    logic                               wb_reg_write;
    logic [rv_mem_pkg::REG_ADDR_W-1:0]  wb_rd;
    logic [rv_mem_pkg::DATA_W-1:0]      wb_writedata;
    logic                               wb_load_misaligned;
    logic                               wb_store_misaligned;

    // Fields of one input line
    logic                               in_stall;
    logic                               in_flush;
    logic                               in_valid;
    logic                               in_reg_write;
    logic [rv_mem_pkg::REG_ADDR_W-1:0]  in_rd;
    logic                               in_mem_read;
    logic                               in_mem_write;
    logic [2:0]                         in_op;
    logic [rv_mem_pkg::DATA_W-1:0]      in_alu;
    logic [rv_mem_pkg::DATA_W-1:0]      in_wdata;
    // 0 no check, 1 control only, 2 control and data
    logic [1:0]                         in_chk;
    logic                               exp_valid;
    logic                               exp_reg_write;
    logic [rv_mem_pkg::REG_ADDR_W-1:0]  exp_rd;
    logic                               exp_lm;
    logic                               exp_sm;
    logic [rv_mem_pkg::DATA_W-1:0]      exp_data;

    rv_mem_pkg::mem2wb_ctrl_t           exp_ctrl;
    rv_mem_pkg::mem2wb_ctrl_t           act_ctrl;

    int                                 fd;
    int                                 got;
    int                                 fields;
    int                                 cycles;
    int                                 lines;
    string                              line;

    rv_mem_top rv_mem_top_inst (
        .clk                 (clk),
        .rst                 (rst),
        .stall               (stall),
        .flush               (flush),
        .ex_valid            (ex_valid),
        .ex_reg_write        (ex_reg_write),
        .ex_rd               (ex_rd),
        .ex_mem_read         (ex_mem_read),
        .ex_mem_write        (ex_mem_write),
        .ex_mem_opcode       (ex_mem_opcode),
        .ex_alu_out          (ex_alu_out),
        .ex_writedata        (ex_writedata),
        .wb_valid            (wb_valid),
        .wb_reg_write        (wb_reg_write),
        .wb_rd               (wb_rd),
        .wb_writedata        (wb_writedata),
        .wb_load_misaligned  (wb_load_misaligned),
        .wb_store_misaligned (wb_store_misaligned)
    );

    // Observed write-back record
    assign act_ctrl = '{valid: wb_valid, reg_write: wb_reg_write, rd: wb_rd,
                        load_misaligned: wb_load_misaligned,
                        store_misaligned: wb_store_misaligned};

    // 100 ns clock
    initial begin
        clk = 1'b0;
        forever #(CLK_HALF) clk = ~clk;
    end

    // ------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------

    task automatic abort_run();
        $display("Simulation FAILED");
        $fatal(1, "testbench stopped on error");
    endtask

    task automatic check_ctrl(input rv_mem_pkg::mem2wb_ctrl_t expected,
                              input rv_mem_pkg::mem2wb_ctrl_t actual);
        if (actual !== expected) begin
            $display("Fail time=%0t signal=wb_ctrl expected=%b actual=%b",
                     $time, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_data(input logic [rv_mem_pkg::DATA_W-1:0] expected,
                              input logic [rv_mem_pkg::DATA_W-1:0] actual);
        if (actual !== expected) begin
            $display("Fail time=%0t signal=wb_writedata expected=%h actual=%h",
                     $time, expected, actual);
            abort_run();
        end
    endtask

    // Blank lines and # lines carry no stimulus
    function automatic bit skip_line(input string text);
        if (text.len() == 0) begin
            return 1'b1;
        end
        return (text.getc(0) == "#") || (text.getc(0) == "\n") || (text.getc(0) == "\r");
    endfunction

    task automatic clear_inputs();
        stall         = 1'b0;
        flush         = 1'b0;
        ex_valid      = 1'b0;
        ex_reg_write  = 1'b0;
        ex_rd         = '0;
        ex_mem_read   = 1'b0;
        ex_mem_write  = 1'b0;
        ex_mem_opcode = rv_mem_pkg::MEM_LB;
        ex_alu_out    = '0;
        ex_writedata  = '0;
    endtask

    // Line inputs go to the DUT and the expected record is packed
    task automatic drive_inputs();
        stall         = in_stall;
        flush         = in_flush;
        ex_valid      = in_valid;
        ex_reg_write  = in_reg_write;
        ex_rd         = in_rd;
        ex_mem_read   = in_mem_read;
        ex_mem_write  = in_mem_write;
        ex_mem_opcode = rv_mem_pkg::mem_op_e'(in_op);
        ex_alu_out    = in_alu;
        ex_writedata  = in_wdata;
        exp_ctrl      = '{valid: exp_valid, reg_write: exp_reg_write, rd: exp_rd,
                          load_misaligned: exp_lm, store_misaligned: exp_sm};
    endtask

    // ------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------

    initial begin
        void'($urandom(32'h87c6));
        rst = 1'b1;
        clear_inputs();
        lines  = 0;
        cycles = 0;
        fd = $fopen("test/rv_mem_input.txt", "r");
        if (fd == 0) begin
            $display("Input file test/rv_mem_input.txt could not be opened");
            abort_run();
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #(DRIVE_DELAY);
        rst = 1'b0;
        // One data line per cycle, driven after the edge and sampled before the next
        while (!$feof(fd)) begin
            cycles++;
            if (cycles > MAX_CYCLES) begin
                $display("Timeout, input file still not consumed after %0d lines", MAX_CYCLES);
                abort_run();
            end
            got = $fgets(line, fd);
            if (got != 0 && !skip_line(line)) begin
                fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                 in_stall, in_flush, in_valid, in_reg_write, in_rd,
                                 in_mem_read, in_mem_write, in_op, in_alu, in_wdata,
                                 in_chk, exp_valid, exp_reg_write, exp_rd,
                                 exp_lm, exp_sm, exp_data);
                if (fields != FIELDS) begin
                    $display("Input line %0d holds %0d fields where %0d are needed",
                             lines + 1, fields, FIELDS);
                    abort_run();
                end
                drive_inputs();
                #(SAMPLE_DELAY);
                if (in_chk != 2'd0) begin
                    check_ctrl(exp_ctrl, act_ctrl);
                end
                if (in_chk == 2'd2) begin
                    check_data(exp_data, wb_writedata);
                end
                @(posedge clk);
                #(DRIVE_DELAY);
                lines++;
            end
        end
        $fclose(fd);
        if (lines < MIN_LINES) begin
            $display("Input file is short, %0d of %0d lines read", lines, MIN_LINES);
            abort_run();
        end else begin
            $display("Simulation PASSED");
            $finish;
        end
    end

endmodule

//--- hdl/rv_mem_top.sv
// ----------------------------------------------------------------------
// Memory stage subsystem top with plain ports
// EX side in, write-back record out two advances later
// ----------------------------------------------------------------------

`timescale 1ns/100ps

module rv_mem_top #(
    parameter int RAM_DEPTH = 256
) (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                stall,
    input  logic                                flush,
    input  logic                                ex_valid,
    input  logic                                ex_reg_write,
    input  logic [rv_mem_pkg::REG_ADDR_W-1:0]   ex_rd,
    input  logic                                ex_mem_read,
    input  logic                                ex_mem_write,
    input  rv_mem_pkg::mem_op_e                 ex_mem_opcode,
    input  logic [rv_mem_pkg::DATA_W-1:0]       ex_alu_out,
    input  logic [rv_mem_pkg::DATA_W-1:0]       ex_writedata,
    output logic                                wb_valid,
    output logic                                wb_reg_write,
    output logic [rv_mem_pkg::REG_ADDR_W-1:0]   wb_rd,
    output logic [rv_mem_pkg::DATA_W-1:0]       wb_writedata,
    output logic                                wb_load_misaligned,
    output logic                                wb_store_misaligned
);

    logic                               advance;
    logic [rv_mem_pkg::DATA_W-1:0]      load_data;
    logic                               load_valid;
    logic                               load_misaligned;
    logic                               store_misaligned;
    rv_mem_pkg::ex2mem_ctrl_t           ex_ctrl;
    rv_mem_pkg::mem2wb_ctrl_t           wb_ctrl;

    dbus_if dbus ();

    // Pack the EX control record
    assign ex_ctrl = '{valid: ex_valid, reg_write: ex_reg_write, rd: ex_rd,
                       mem_read: ex_mem_read, opcode: ex_mem_opcode};

    // Unpack the write-back record
    assign wb_valid            = wb_ctrl.valid;
    assign wb_reg_write        = wb_ctrl.reg_write;
    assign wb_rd               = wb_ctrl.rd;
    assign wb_load_misaligned  = wb_ctrl.load_misaligned;
    assign wb_store_misaligned = wb_ctrl.store_misaligned;

    // Effective address is the ALU result
    lsu lsu_inst (
        .clk              (clk),
        .rst              (rst),
        .advance          (advance),
        .mem_read         (ex_mem_read),
        .mem_write        (ex_mem_write),
        .mem_opcode       (ex_mem_opcode),
        .address          (ex_alu_out),
        .writedata        (ex_writedata),
        .dbus             (dbus.requester),
        .load_data        (load_data),
        .load_valid       (load_valid),
        .load_misaligned  (load_misaligned),
        .store_misaligned (store_misaligned)
    );

    data_ram #(.RAM_DEPTH(RAM_DEPTH)) data_ram_inst (
        .clk  (clk),
        .rst  (rst),
        .dbus (dbus.memory)
    );

    mem_stage mem_stage_inst (
        .clk              (clk),
        .rst              (rst),
        .stall            (stall),
        .flush            (flush),
        .ex_ctrl          (ex_ctrl),
        .ex_alu_out       (ex_alu_out),
        .load_data        (load_data),
        .load_valid       (load_valid),
        .load_misaligned  (load_misaligned),
        .store_misaligned (store_misaligned),
        .advance          (advance),
        .wb_ctrl          (wb_ctrl),
        .wb_writedata     (wb_writedata)
    );

endmodule

//--- hdl/mem_stage.sv
// ----------------------------------------------------------------------
// EX/MEM and MEM/WB pipeline registers of the memory stage
// Applies stall and flush, picks load data or ALU result for WB
// ----------------------------------------------------------------------

`timescale 1ns/100ps

module mem_stage (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            stall,
    input  logic                            flush,
    input  rv_mem_pkg::ex2mem_ctrl_t        ex_ctrl,
    input  logic [rv_mem_pkg::DATA_W-1:0]   ex_alu_out,
    input  logic [rv_mem_pkg::DATA_W-1:0]   load_data,
    input  logic                            load_valid,
    input  logic                            load_misaligned,
    input  logic                            store_misaligned,
    output logic                            advance,
    output rv_mem_pkg::mem2wb_ctrl_t        wb_ctrl,
    output logic [rv_mem_pkg::DATA_W-1:0]   wb_writedata
);

    rv_mem_pkg::ex2mem_ctrl_t           mem_ctrl;
    logic [rv_mem_pkg::DATA_W-1:0]      mem_alu_out;
    rv_mem_pkg::mem2wb_ctrl_t           mem_wb_next;
    logic                               use_load;

    // Whole pipe moves unless stalled
    assign advance = !stall;

    // ------------------------------------------------------------------
    // EX/MEM
    // ------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            mem_ctrl <= '0;
        end else if (advance) begin
            mem_ctrl <= ex_ctrl;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            mem_alu_out <= ex_alu_out;
        end
    end

    // ------------------------------------------------------------------
    // MEM/WB
    // ------------------------------------------------------------------

    // MEM record plus the flags from the LSU
    always_comb begin
        mem_wb_next.valid            = mem_ctrl.valid;
        mem_wb_next.reg_write        = mem_ctrl.reg_write;
        mem_wb_next.rd               = mem_ctrl.rd;
        mem_wb_next.load_misaligned  = load_misaligned;
        mem_wb_next.store_misaligned = store_misaligned;
    end

    // Misaligned loads never return data and fall back to the ALU value
    assign use_load = mem_ctrl.valid && mem_ctrl.mem_read && load_valid;

    // Bubble on flush or on an empty MEM slot
    always_ff @(posedge clk) begin
        if (rst) begin
            wb_ctrl <= '0;
        end else if (advance) begin
            if (flush || !mem_ctrl.valid) begin
                wb_ctrl <= '0;
            end else begin
                wb_ctrl <= mem_wb_next;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            wb_writedata <= use_load ? load_data : mem_alu_out;
        end
    end

endmodule

//--- hdl/data_ram.sv
// ----------------------------------------------------------------------
// Byte-enabled data RAM on the memory side of the data bus
// One cycle read latency, never stalls the requester
// ----------------------------------------------------------------------

`timescale 1ns/100ps

module data_ram #(
    parameter int RAM_DEPTH = 256
) (
    input  logic        clk,
    input  logic        rst,
    dbus_if.memory      dbus
);

    // Index bits sit just above the byte offset
    localparam int IDX_W = $clog2(RAM_DEPTH);

    rv_mem_pkg::data_word_u    mem [RAM_DEPTH];
    rv_mem_pkg::data_word_u    wdata;
    logic [IDX_W-1:0]          idx;

    // Upper address bits dropped, so accesses wrap
    assign idx   = dbus.address[IDX_W-1:0];
    assign wdata = dbus.writedata;

    // Contents start cleared
    initial begin
        for (int i = 0; i < RAM_DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    // Write lands on the edge that samples the strobe
    always_ff @(posedge clk) begin
        if (dbus.write) begin
            for (int b = 0; b < 4; b++) begin
                if (dbus.byteenable[b]) begin
                    mem[idx].bytes[b] <= wdata.bytes[b];
                end
            end
        end
    end

    // Read word, valid strobe one cycle behind the request
    always_ff @(posedge clk) begin
        if (dbus.read) begin
            dbus.readdata <= mem[idx].word;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            dbus.readdatavalid <= 1'b0;
        end else begin
            dbus.readdatavalid <= dbus.read;
        end
    end

endmodule

//--- hdl/lsu.sv
// ----------------------------------------------------------------------
// Load/store unit of the memory stage
// Issues aligned accesses in EX, formats and holds load data for MEM
// ----------------------------------------------------------------------

`timescale 1ns/100ps

module lsu (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            advance,
    input  logic                            mem_read,
    input  logic                            mem_write,
    input  rv_mem_pkg::mem_op_e             mem_opcode,
    input  logic [rv_mem_pkg::DATA_W-1:0]   address,
    input  logic [rv_mem_pkg::DATA_W-1:0]   writedata,
    dbus_if.requester                       dbus,
    output logic [rv_mem_pkg::DATA_W-1:0]   load_data,
    output logic                            load_valid,
    output logic                            load_misaligned,
    output logic                            store_misaligned
);

    // ------------------------------------------------------------------
    // EX side: alignment and request
    // ------------------------------------------------------------------

    logic                       is_half;
    logic                       is_word;
    logic                       misaligned;
    rv_mem_pkg::data_word_u     store_word;
    rv_mem_pkg::data_word_u     load_word;
    logic [rv_mem_pkg::DATA_W-1:0] load_fmt;

    // Registered for the MEM cycle
    rv_mem_pkg::mem_op_e        op_q;
    logic [1:0]                 offset_q;
    logic [rv_mem_pkg::DATA_W-1:0] hold_data;
    logic                       hold_valid;

    assign is_half = (mem_opcode == rv_mem_pkg::MEM_LH) || (mem_opcode == rv_mem_pkg::MEM_LHU) ||
                     (mem_opcode == rv_mem_pkg::MEM_SH);
    assign is_word = (mem_opcode == rv_mem_pkg::MEM_LW) || (mem_opcode == rv_mem_pkg::MEM_SW);
    assign misaligned = (is_half && address[0]) || (is_word && (address[1:0] != 2'b00));

    // No bus access while stalled or misaligned
    assign dbus.read    = mem_read && !misaligned && advance;
    assign dbus.write   = mem_write && !misaligned && advance;
    assign dbus.address = address[rv_mem_pkg::DATA_W-1:2];

    // Store data replicated over the lanes, enables pick the lanes
    always_comb begin
        store_word.word = writedata;
        dbus.byteenable = 4'b1111;
        case (mem_opcode)
            rv_mem_pkg::MEM_SB: begin
                store_word.bytes = {4{writedata[7:0]}};
                dbus.byteenable  = 4'b0001 << address[1:0];
            end
            rv_mem_pkg::MEM_SH: begin
                store_word.halves = {2{writedata[15:0]}};
                dbus.byteenable   = 4'b0011 << {address[1], 1'b0};
            end
            default: ;
        endcase
    end

    assign dbus.writedata = store_word.word;

    // Format and flags follow the access into MEM
    always_ff @(posedge clk) begin
        if (advance) begin
            op_q     <= mem_opcode;
            offset_q <= address[1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            load_misaligned  <= 1'b0;
            store_misaligned <= 1'b0;
        end else if (advance) begin
            load_misaligned  <= mem_read && misaligned;
            store_misaligned <= mem_write && misaligned;
        end
    end

    // ------------------------------------------------------------------
    // MEM side: load formatting and hold
    // ------------------------------------------------------------------

    assign load_word.word = dbus.readdata;

    always_comb begin
        case (op_q)
            rv_mem_pkg::MEM_LB:  load_fmt = {{24{load_word.bytes[offset_q][7]}},
                                             load_word.bytes[offset_q]};
            rv_mem_pkg::MEM_LBU: load_fmt = {24'b0, load_word.bytes[offset_q]};
            rv_mem_pkg::MEM_LH:  load_fmt = {{16{load_word.halves[offset_q[1]][15]}},
                                             load_word.halves[offset_q[1]]};
            rv_mem_pkg::MEM_LHU: load_fmt = {16'b0, load_word.halves[offset_q[1]]};
            default:             load_fmt = load_word.word;
        endcase
    end

    // Keeps a result that returned during a stall until the next advance
    always_ff @(posedge clk) begin
        if (rst) begin
            hold_valid <= 1'b0;
        end else if (advance) begin
            hold_valid <= 1'b0;
        end else if (dbus.readdatavalid) begin
            hold_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (dbus.readdatavalid) begin
            hold_data <= load_fmt;
        end
    end

    assign load_data  = hold_valid ? hold_data : load_fmt;
    assign load_valid = hold_valid || dbus.readdatavalid;

endmodule

//--- hdl/dbus_if.sv
// ----------------------------------------------------------------------
// Data bus between the load/store unit and the data RAM
// Plain strobes, one cycle read latency, no wait states
// ----------------------------------------------------------------------

`timescale 1ns/100ps

interface dbus_if;

    // Request side
    logic                               read;
    logic                               write;
    // Word address, byte offset already dropped
    logic [rv_mem_pkg::DATA_W-3:0]      address;
    logic [3:0]                         byteenable;
    logic [rv_mem_pkg::DATA_W-1:0]      writedata;

    // Response side
    logic [rv_mem_pkg::DATA_W-1:0]      readdata;
    logic                               readdatavalid;

    modport requester (
        output read, write, address, byteenable, writedata,
        input  readdata, readdatavalid
    );

    modport memory (
        input  read, write, address, byteenable, writedata,
        output readdata, readdatavalid
    );

endinterface

//--- hdl/rv_mem_pkg.sv
// ----------------------------------------------------------------------
// Shared widths, opcodes and pipeline records of the memory stage
// Referenced by scoped names from the RTL and the testbench
// ----------------------------------------------------------------------

package rv_mem_pkg;

    // Data path and address width
    localparam int DATA_W = 32;
    // Register file index width
    localparam int REG_ADDR_W = 5;

    // Memory opcode
    // Loads keep their funct3 code, stores take the codes loads leave free
    typedef enum logic [2:0] {
        MEM_LB  = 3'b000,
        MEM_LH  = 3'b001,
        MEM_LW  = 3'b010,
        MEM_SW  = 3'b011,
        MEM_LBU = 3'b100,
        MEM_LHU = 3'b101,
        MEM_SB  = 3'b110,
        MEM_SH  = 3'b111
    } mem_op_e;

    // One bus word seen as a whole, as bytes or as halfwords
    typedef union packed {
        logic [DATA_W-1:0]    word;
        logic [3:0][7:0]      bytes;
        logic [1:0][15:0]     halves;
    } data_word_u;

    // EX/MEM control record
    typedef struct packed {
        logic                     valid;
        logic                     reg_write;
        logic [REG_ADDR_W-1:0]    rd;
        logic                     mem_read;
        mem_op_e                  opcode;
    } ex2mem_ctrl_t;

    // MEM/WB control record, all zero is a bubble
    typedef struct packed {
        logic                     valid;
        logic                     reg_write;
        logic [REG_ADDR_W-1:0]    rd;
        logic                     load_misaligned;
        logic                     store_misaligned;
    } mem2wb_ctrl_t;

endpackage
